//--- all.f
rtl/sd_pkg.sv
rtl/sd_regs.sv
rtl/sd_clock_divider.sv
rtl/sd_cmd_master.sv
rtl/sd_cmd_serial_host.sv
rtl/sd_controller_top.sv
sim/sd_card_model.sv
sim/tb_sd_controller.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_sd_controller
SIM_DIR ?= obj_dir
FILELIST ?= all.f
VERILATOR_FLAGS ?= --binary --timing --assert -sv

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(SIM_DIR)

//--- sim/tb_sd_controller.sv
module tb_sd_controller;
    import sd_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESP_TIMEOUT = 64;
    localparam int NUM_TESTS = 6;
    localparam int SD_DIV = int'(DIVISOR_RESET) + 1;
    // frame out, response in, timeout window, two bus phases per SD clock
    localparam int CMD_CYCLES = (2 * CMD_FRAME_LEN + RESP_TIMEOUT) * SD_DIV * 2;
    localparam int WATCHDOG_TIME = NUM_TESTS * 4 * CMD_CYCLES * CLK_PERIOD;
    localparam int ACK_LIMIT = 4;

    logic        wb_clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        int_o;
    logic        sd_clk;
    logic        sd_cmd_to_card;
    logic        sd_cmd_oe;
    logic        sd_cmd_from_card;
    logic        bad_crc;
    logic        bad_index;
    logic        silent;
    int          frame_cnt;
    int          frame_err_cnt;
    integer      seed;
    int          errors;
    int          checks;
    int          tests_run;
    int          test_start_errors;

    sd_controller_top #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) dut0 (
        .wb_clk_i    (wb_clk),
        .rst_n_i     (rst_n),
        .wb_cyc_i    (wb_cyc),
        .wb_stb_i    (wb_stb),
        .wb_we_i     (wb_we),
        .wb_adr_i    (wb_adr),
        .wb_dat_i    (wb_dat_w),
        .wb_dat_o    (wb_dat_r),
        .wb_ack_o    (wb_ack),
        .int_o       (int_o),
        .sd_clk_o    (sd_clk),
        .sd_cmd_i    (sd_cmd_from_card),
        .sd_cmd_o    (sd_cmd_to_card),
        .sd_cmd_oe_o (sd_cmd_oe)
    );

    sd_card_model card0 (
        .sd_clk_i        (sd_clk),
        .cmd_i           (sd_cmd_to_card),
        .cmd_oe_i        (sd_cmd_oe),
        .bad_crc_i       (bad_crc),
        .bad_index_i     (bad_index),
        .silent_i        (silent),
        .cmd_o           (sd_cmd_from_card),
        .frame_cnt_o     (frame_cnt),
        .frame_err_cnt_o (frame_err_cnt)
    );

    initial begin
        wb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) wb_clk = ~wb_clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before the tests finished");
        $display("RESULT: FAIL");
        $finish;
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input sd_int_status_t got,
                                input sd_int_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic sd_int_status_t status_of(input logic complete, input logic crc,
                                                 input logic idx, input logic to);
        sd_int_status_t s;
        s.cmd_complete = complete;
        s.crc_error = crc;
        s.index_error = idx;
        s.timeout = to;
        return s;
    endfunction

    // one classic cycle, driven on the falling edge, held until ack
    task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        @(negedge wb_clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdat;
        n = 0;
        @(negedge wb_clk);
        while (!wb_ack && n < ACK_LIMIT) begin
            @(negedge wb_clk);
            n++;
        end
        if (!wb_ack) begin
            errors++;
            $display("no ack from the register block at address %h", adr);
        end
        rdat = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
        bus_cycle(1'b0, adr, 32'h0, dat);
    endtask

    task automatic read_status(output sd_int_status_t st);
        logic [31:0] rd;
        wb_read(REG_INT_STATUS, rd);
        st = sd_int_status_t'(rd[3:0]);
    endtask

    task automatic issue_cmd(input logic [5:0] index, input logic [31:0] arg,
                             input sd_resp_e resp);
        wb_write(REG_ARGUMENT, arg);
        wb_write(REG_COMMAND, {23'h0, resp, 2'b00, index});
    endtask

    task automatic wait_complete();
        logic [31:0] st;
        int n;
        st = '0;
        n = 0;
        while (!st[0] && n < CMD_CYCLES) begin
            wb_read(REG_INT_STATUS, st);
            n++;
        end
        if (!st[0]) begin
            errors++;
            $display("command never reported completion");
        end
    endtask

    task automatic run_cmd_expect(input string name, input logic [5:0] index,
                                  input sd_resp_e resp, input sd_int_status_t exp);
        logic [31:0] arg;
        sd_int_status_t st;
        arg = $random(seed);
        issue_cmd(index, arg, resp);
        wait_complete();
        read_status(st);
        check_status(name, st, exp);
        wb_write(REG_INT_STATUS, 32'hF);
    endtask

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
    endtask

    task automatic test_reset_values();
        logic [31:0] rd;
        start_test();
        wb_read(REG_INT_STATUS, rd);
        check_word("INT_STATUS", rd, 32'h0);
        wb_read(REG_INT_ENABLE, rd);
        check_word("INT_ENABLE", rd, 32'h0);
        wb_read(REG_CLOCK_DIV, rd);
        check_word("CLOCK_DIV", rd, {24'h0, DIVISOR_RESET});
        wb_read(REG_PRESENT, rd);
        check_word("PRESENT.cmd_inhibit", {31'h0, rd[0]}, 32'h0);
        check_word("int_o", {31'h0, int_o}, 32'h0);
        // one full SD period is 2 * (DIVISOR+1) bus cycles
        repeat (2 * SD_DIV) @(negedge wb_clk);
        wb_read(REG_PRESENT, rd);
        check_word("PRESENT.clk_stable", {31'h0, rd[1]}, 32'h1);
        end_test("reset values");
    endtask

    task automatic test_readback();
        logic [31:0] arg;
        logic [31:0] rd;
        start_test();
        arg = $random(seed);
        wb_write(REG_ARGUMENT, arg);
        wb_read(REG_ARGUMENT, rd);
        check_word("ARGUMENT", rd, arg);
        wb_write(REG_INT_ENABLE, 32'hFFFF_FFF5);
        wb_read(REG_INT_ENABLE, rd);
        check_word("INT_ENABLE", rd, 32'h5);
        wb_write(REG_INT_ENABLE, 32'h0);
        wb_write(REG_CLOCK_DIV, 32'h0000_0105);
        wb_read(REG_CLOCK_DIV, rd);
        check_word("CLOCK_DIV", rd, 32'h5);
        wb_write(REG_CLOCK_DIV, {24'h0, DIVISOR_RESET});
        wb_read(8'h1C, rd);
        check_word("unmapped 0x1C", rd, 32'h0);
        wb_read(8'h40, rd);
        check_word("unmapped 0x40", rd, 32'h0);
        end_test("register read-back");
    endtask

    task automatic test_short_response();
        logic [31:0] arg;
        logic [31:0] rd;
        sd_int_status_t st;
        int frames;
        int frame_errs;
        start_test();
        frames = frame_cnt;
        frame_errs = frame_err_cnt;
        wb_write(REG_INT_ENABLE, 32'h1);
        arg = $random(seed);
        issue_cmd(6'd17, arg, RESP_SHORT);
        wait_complete();
        read_status(st);
        check_status("INT_STATUS", st, status_of(1'b1, 1'b0, 1'b0, 1'b0));
        check_word("int_o", {31'h0, int_o}, 32'h1);
        wb_read(REG_RESPONSE, rd);
        check_word("RESPONSE", rd, ~arg);
        check_word("card frame count", frame_cnt, frames + 1);
        check_word("card frame errors", frame_err_cnt, frame_errs);
        wb_write(REG_INT_STATUS, 32'hF);
        wb_write(REG_INT_ENABLE, 32'h0);
        check_word("int_o", {31'h0, int_o}, 32'h0);
        end_test("short response");
    endtask

    task automatic test_error_injection();
        start_test();
        bad_crc = 1'b1;
        run_cmd_expect("INT_STATUS bad crc", 6'd8, RESP_SHORT,
                       status_of(1'b1, 1'b1, 1'b0, 1'b0));
        bad_crc = 1'b0;
        bad_index = 1'b1;
        run_cmd_expect("INT_STATUS bad index", 6'd8, RESP_SHORT,
                       status_of(1'b1, 1'b0, 1'b1, 1'b0));
        bad_index = 1'b0;
        end_test("error injection");
    endtask

    task automatic test_silent_card();
        int frames;
        int frame_errs;
        start_test();
        silent = 1'b1;
        run_cmd_expect("INT_STATUS silent", 6'd2, RESP_SHORT,
                       status_of(1'b1, 1'b0, 1'b0, 1'b1));
        frames = frame_cnt;
        frame_errs = frame_err_cnt;
        run_cmd_expect("INT_STATUS no response", 6'd0, RESP_NONE,
                       status_of(1'b1, 1'b0, 1'b0, 1'b0));
        check_word("card frame count", frame_cnt, frames + 1);
        check_word("card frame errors", frame_err_cnt, frame_errs);
        silent = 1'b0;
        end_test("silent card");
    endtask

    task automatic test_clear_and_mask();
        logic [31:0] rd;
        sd_int_status_t st;
        int frames;
        start_test();
        bad_crc = 1'b1;
        issue_cmd(6'd3, $random(seed), RESP_SHORT);
        wait_complete();
        bad_crc = 1'b0;
        wb_write(REG_INT_ENABLE, 32'h2);
        check_word("int_o", {31'h0, int_o}, 32'h1);
        wb_write(REG_INT_STATUS, 32'h2);
        read_status(st);
        check_status("INT_STATUS", st, status_of(1'b1, 1'b0, 1'b0, 1'b0));
        check_word("int_o", {31'h0, int_o}, 32'h0);
        wb_write(REG_INT_ENABLE, 32'h1);
        check_word("int_o", {31'h0, int_o}, 32'h1);
        wb_write(REG_INT_STATUS, 32'h1);
        read_status(st);
        check_status("INT_STATUS", st, status_of(1'b0, 1'b0, 1'b0, 1'b0));
        check_word("int_o", {31'h0, int_o}, 32'h0);
        wb_write(REG_INT_ENABLE, 32'h0);
        // second write lands while the first command is in flight
        frames = frame_cnt;
        issue_cmd(6'd5, $random(seed), RESP_SHORT);
        wb_read(REG_PRESENT, rd);
        check_word("PRESENT.cmd_inhibit", {31'h0, rd[0]}, 32'h1);
        wb_write(REG_COMMAND, {23'h0, RESP_SHORT, 2'b00, 6'd9});
        wait_complete();
        wb_read(REG_COMMAND, rd);
        check_word("COMMAND", rd, 32'h0000_0105);
        wb_read(REG_PRESENT, rd);
        check_word("PRESENT.cmd_inhibit", {31'h0, rd[0]}, 32'h0);
        check_word("card frame count", frame_cnt, frames + 1);
        wb_write(REG_INT_STATUS, 32'hF);
        end_test("clear and mask");
    endtask

    initial begin
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = 8'h0;
        wb_dat_w = 32'h0;
        bad_crc = 1'b0;
        bad_index = 1'b0;
        silent = 1'b0;
        seed = 32'hcf78;
        errors = 0;
        checks = 0;
        tests_run = 0;
        test_start_errors = 0;
        repeat (16) @(posedge wb_clk);
        @(negedge wb_clk);
        rst_n = 1'b1;
        test_reset_values();
        test_readback();
        test_short_response();
        test_error_injection();
        test_silent_card();
        test_clear_and_mask();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/sd_card_model.sv
module sd_card_model (
    input  logic sd_clk_i,
    input  logic cmd_i,
    input  logic cmd_oe_i,
    input  logic bad_crc_i,
    input  logic bad_index_i,
    input  logic silent_i,
    output logic cmd_o,
    output int   frame_cnt_o,
    output int   frame_err_cnt_o
);
    import sd_pkg::*;

    logic [CMD_FRAME_LEN-1:0] rx;
    int                       nbits;

    // remainder of body * x^7 divided by x^7 + x^3 + 1
    function automatic logic [CRC7_W-1:0] crc7(input logic [CMD_FRAME_LEN-CRC7_W-2:0] body);
        logic [CMD_FRAME_LEN-2:0] v;
        v = {body, 7'h00};
        for (int i = CMD_FRAME_LEN - 2; i >= CRC7_W; i--) begin
            if (v[i]) begin
                v[i -: 8] = v[i -: 8] ^ 8'h89;
            end
        end
        return v[CRC7_W-1:0];
    endfunction

    task automatic answer(input logic [CMD_INDEX_W-1:0] idx, input logic [ARG_W-1:0] arg);
        logic [CMD_FRAME_LEN-1:0] rsp;
        logic [CMD_INDEX_W-1:0]   ridx;
        ridx = bad_index_i ? idx + 6'd1 : idx;
        // start bit, transmission bit 0 for a card, index, payload
        rsp[47:8] = {1'b0, 1'b0, ridx, ~arg};
        rsp[7:1] = crc7(rsp[47:8]) ^ (bad_crc_i ? 7'h01 : 7'h00);
        rsp[0] = 1'b1;
        repeat (4) @(negedge sd_clk_i);
        for (int i = CMD_FRAME_LEN - 1; i >= 0; i--) begin
            cmd_o = rsp[i];
            @(negedge sd_clk_i);
        end
        cmd_o = 1'b1;
    endtask

    initial begin
        cmd_o = 1'b1;
        frame_cnt_o = 0;
        frame_err_cnt_o = 0;
        nbits = 0;
        rx = '0;
    end

    always @(posedge sd_clk_i) begin
        if (cmd_oe_i) begin
            rx = {rx[CMD_FRAME_LEN-2:0], cmd_i};
            nbits = nbits + 1;
            if (nbits == CMD_FRAME_LEN) begin
                nbits = 0;
                frame_cnt_o = frame_cnt_o + 1;
                if (rx[47] !== 1'b0 || rx[46] !== 1'b1 || rx[0] !== 1'b1 ||
                    crc7(rx[47:8]) !== rx[7:1]) begin
                    frame_err_cnt_o = frame_err_cnt_o + 1;
                end else if (!silent_i) begin
                    answer(rx[45:40], rx[39:8]);
                end
            end
        end
    end

endmodule

//--- rtl/sd_controller_top.sv
module sd_controller_top #(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic        wb_clk_i,
    input  logic        rst_n_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [7:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    output logic        int_o,
    output logic        sd_clk_o,
    input  logic        sd_cmd_i,
    output logic        sd_cmd_o,
    output logic        sd_cmd_oe_o
);
    import sd_pkg::*;

    logic              cmd_start;
    sd_cmd_req_t       cmd_req;
    logic [DIV_W-1:0]  divisor;
    logic              clk_stable;
    logic              drive_stb;
    logic              sample_stb;
    logic              cmd_inhibit;
    sd_cmd_event_t     cmd_event;
    logic              xfr_start;
    sd_cmd_req_t       xfr_req;
    logic              xfr_done;
    sd_cmd_frame_rsp_t xfr_rsp;

    sd_regs u_regs (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .cmd_inhibit_i (cmd_inhibit),
        .clk_stable_i  (clk_stable),
        .event_i       (cmd_event),
        .cmd_start_o   (cmd_start),
        .cmd_req_o     (cmd_req),
        .divisor_o     (divisor),
        .int_o         (int_o)
    );

    sd_clock_divider u_clock_divider (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .divisor_i    (divisor),
        .sd_clk_o     (sd_clk_o),
        .drive_stb_o  (drive_stb),
        .sample_stb_o (sample_stb),
        .clk_stable_o (clk_stable)
    );

    sd_cmd_master u_cmd_master (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .cmd_start_i   (cmd_start),
        .cmd_req_i     (cmd_req),
        .xfr_start_o   (xfr_start),
        .xfr_req_o     (xfr_req),
        .xfr_done_i    (xfr_done),
        .xfr_rsp_i     (xfr_rsp),
        .cmd_inhibit_o (cmd_inhibit),
        .event_o       (cmd_event)
    );

    sd_cmd_serial_host #(
        .RESP_TIMEOUT (RESP_TIMEOUT)
    ) u_cmd_serial_host (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .drive_stb_i  (drive_stb),
        .sample_stb_i (sample_stb),
        .start_i      (xfr_start),
        .req_i        (xfr_req),
        .done_o       (xfr_done),
        .rsp_o        (xfr_rsp),
        .cmd_i        (sd_cmd_i),
        .cmd_o        (sd_cmd_o),
        .cmd_oe_o     (sd_cmd_oe_o)
    );

endmodule

//--- rtl/sd_cmd_serial_host.sv
module sd_cmd_serial_host #(
    parameter int RESP_TIMEOUT = 64
) (
    input  logic                      wb_clk_i,
    input  logic                      rst_n_i,
    input  logic                      drive_stb_i,
    input  logic                      sample_stb_i,
    input  logic                      start_i,
    input  sd_pkg::sd_cmd_req_t       req_i,
    output logic                      done_o,
    output sd_pkg::sd_cmd_frame_rsp_t rsp_o,
    input  logic                      cmd_i,
    output logic                      cmd_o,
    output logic                      cmd_oe_o
);
    import sd_pkg::*;

    // bits covered by the CRC: start, transmission, index, argument
    localparam int BODY_LEN = CMD_FRAME_LEN - CRC7_W - 1;
    localparam int CNT_W = $clog2(CMD_FRAME_LEN + 1);
    localparam int TO_W = $clog2(RESP_TIMEOUT);

    typedef enum logic [2:0] {
        IDLE,
        SEND,
        WAIT,
        RECV,
        FINISH
    } state_e;

    state_e                   state_q;
    logic [BODY_LEN-1:0]      tx_q;
    logic [CMD_FRAME_LEN-2:0] rx_q;
    logic [CRC7_W-1:0]        crc_q;
    logic [CNT_W-1:0]         bit_cnt_q;
    logic [TO_W-1:0]          to_cnt_q;
    logic                     timeout_q;
    sd_resp_e                 resp_q;

    // x^7 + x^3 + 1, one bit per call
    function automatic logic [CRC7_W-1:0] crc7_step(input logic [CRC7_W-1:0] crc,
                                                    input logic bit_i);
        logic fb;
        fb = bit_i ^ crc[CRC7_W-1];
        crc7_step = {crc[CRC7_W-2:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
    endfunction

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            tx_q <= '0;
            rx_q <= '0;
            crc_q <= '0;
            bit_cnt_q <= '0;
            to_cnt_q <= '0;
            timeout_q <= 1'b0;
            resp_q <= RESP_NONE;
            cmd_o <= 1'b1;
            cmd_oe_o <= 1'b0;
            done_o <= 1'b0;
            rsp_o <= '0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        tx_q <= {1'b0, 1'b1, req_i.index, req_i.argument};
                        rx_q <= '0;
                        crc_q <= '0;
                        bit_cnt_q <= '0;
                        timeout_q <= 1'b0;
                        resp_q <= req_i.resp;
                        state_q <= SEND;
                    end
                end
                SEND: begin
                    if (drive_stb_i) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        cmd_oe_o <= 1'b1;
                        if (bit_cnt_q < CNT_W'(BODY_LEN)) begin
                            cmd_o <= tx_q[BODY_LEN-1];
                            tx_q <= {tx_q[BODY_LEN-2:0], 1'b0};
                            crc_q <= crc7_step(crc_q, tx_q[BODY_LEN-1]);
                        end else if (bit_cnt_q < CNT_W'(CMD_FRAME_LEN - 1)) begin
                            cmd_o <= crc_q[CRC7_W-1];
                            crc_q <= {crc_q[CRC7_W-2:0], 1'b0};
                        end else if (bit_cnt_q == CNT_W'(CMD_FRAME_LEN - 1)) begin
                            // end bit
                            cmd_o <= 1'b1;
                        end else begin
                            cmd_oe_o <= 1'b0;
                            cmd_o <= 1'b1;
                            to_cnt_q <= '0;
                            state_q <= (resp_q == RESP_SHORT) ? WAIT : FINISH;
                        end
                    end
                end
                WAIT: begin
                    if (sample_stb_i) begin
                        if (!cmd_i) begin
                            // crc of a single 0 start bit is still zero
                            crc_q <= '0;
                            bit_cnt_q <= CNT_W'(1);
                            state_q <= RECV;
                        end else if (to_cnt_q == TO_W'(RESP_TIMEOUT - 1)) begin
                            timeout_q <= 1'b1;
                            state_q <= FINISH;
                        end else begin
                            to_cnt_q <= to_cnt_q + 1'b1;
                        end
                    end
                end
                RECV: begin
                    if (sample_stb_i) begin
                        rx_q <= {rx_q[CMD_FRAME_LEN-3:0], cmd_i};
                        if (bit_cnt_q < CNT_W'(BODY_LEN)) begin
                            crc_q <= crc7_step(crc_q, cmd_i);
                        end
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == CNT_W'(CMD_FRAME_LEN - 1)) begin
                            state_q <= FINISH;
                        end
                    end
                end
                FINISH: begin
                    done_o <= 1'b1;
                    rsp_o.index <= rx_q[CMD_FRAME_LEN-3 -: CMD_INDEX_W];
                    rsp_o.payload <= rx_q[CRC7_W+ARG_W:CRC7_W+1];
                    rsp_o.crc_ok <= (resp_q == RESP_NONE) || timeout_q ||
                                    (crc_q == rx_q[CRC7_W:1]);
                    rsp_o.timeout <= timeout_q;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    a_oe_only_in_send: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (state_q != SEND) |-> !cmd_oe_o);

endmodule

//--- rtl/sd_cmd_master.sv
module sd_cmd_master (
    input  logic                      wb_clk_i,
    input  logic                      rst_n_i,
    input  logic                      cmd_start_i,
    input  sd_pkg::sd_cmd_req_t       cmd_req_i,
    output logic                      xfr_start_o,
    output sd_pkg::sd_cmd_req_t       xfr_req_o,
    input  logic                      xfr_done_i,
    input  sd_pkg::sd_cmd_frame_rsp_t xfr_rsp_i,
    output logic                      cmd_inhibit_o,
    output sd_pkg::sd_cmd_event_t     event_o
);
    import sd_pkg::*;

    sd_cmd_req_t    req_q;
    logic           busy_q;
    sd_int_status_t status_d;

    always_comb begin
        status_d = '0;
        status_d.cmd_complete = 1'b1;
        status_d.timeout = xfr_rsp_i.timeout;
        status_d.crc_error = ~xfr_rsp_i.crc_ok;
        // index only means something for a response that arrived
        status_d.index_error = (req_q.resp == RESP_SHORT) && !xfr_rsp_i.timeout &&
                               (xfr_rsp_i.index != req_q.index);
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            xfr_start_o <= 1'b0;
            event_o <= '0;
        end else begin
            xfr_start_o <= 1'b0;
            event_o.valid <= 1'b0;
            if (cmd_start_i && !busy_q) begin
                busy_q <= 1'b1;
                xfr_start_o <= 1'b1;
            end else if (xfr_done_i && busy_q) begin
                busy_q <= 1'b0;
                event_o.valid <= 1'b1;
                event_o.status <= status_d;
                event_o.response <= xfr_rsp_i.payload;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (cmd_start_i && !busy_q) begin
            req_q <= cmd_req_i;
        end
    end

    assign xfr_req_o = req_q;
    assign cmd_inhibit_o = busy_q;

    // sd_regs must hold off new commands while one is in flight
    a_one_in_flight: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        cmd_start_i |-> !cmd_inhibit_o);

endmodule

//--- rtl/sd_clock_divider.sv
module sd_clock_divider (
    input  logic                     wb_clk_i,
    input  logic                     rst_n_i,
    input  logic [sd_pkg::DIV_W-1:0] divisor_i,
    output logic                     sd_clk_o,
    output logic                     drive_stb_o,
    output logic                     sample_stb_o,
    output logic                     clk_stable_o
);
    import sd_pkg::*;

    logic [DIV_W-1:0] cnt_q;
    logic             wrap;

    // >= so a smaller divisor written mid-count takes effect at once
    assign wrap = (cnt_q >= divisor_i);

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            sd_clk_o <= 1'b0;
            drive_stb_o <= 1'b0;
            sample_stb_o <= 1'b0;
            clk_stable_o <= 1'b0;
        end else begin
            drive_stb_o <= wrap & sd_clk_o;
            sample_stb_o <= wrap & ~sd_clk_o;
            if (wrap) begin
                cnt_q <= '0;
                sd_clk_o <= ~sd_clk_o;
                // first falling edge closes the first full period
                if (sd_clk_o) begin
                    clk_stable_o <= 1'b1;
                end
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

//--- rtl/sd_regs.sv
module sd_regs (
    input  logic                        wb_clk_i,
    input  logic                        rst_n_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [7:0]                  wb_adr_i,
    input  logic [31:0]                 wb_dat_i,
    output logic [31:0]                 wb_dat_o,
    output logic                        wb_ack_o,
    input  logic                        cmd_inhibit_i,
    input  logic                        clk_stable_i,
    input  sd_pkg::sd_cmd_event_t       event_i,
    output logic                        cmd_start_o,
    output sd_pkg::sd_cmd_req_t         cmd_req_o,
    output logic [sd_pkg::DIV_W-1:0]    divisor_o,
    output logic                        int_o
);
    import sd_pkg::*;

    logic                   req;
    logic                   access;
    logic                   wr;
    logic                   held_q;
    logic [31:0]            rdata;
    logic [ARG_W-1:0]       argument_q;
    logic [ARG_W-1:0]       response_q;
    logic [CMD_INDEX_W-1:0] cmd_index_q;
    sd_resp_e               cmd_resp_q;
    sd_int_status_t         int_status_q;
    sd_int_status_t         int_enable_q;
    sd_int_status_t         status_clr;
    sd_int_status_t         status_set;
    logic [DIV_W-1:0]       divisor_q;

    assign req = wb_cyc_i & wb_stb_i;
    // one ack per strobe until the master drops stb
    assign access = req & ~wb_ack_o & ~held_q;
    assign wr = access & wb_we_i;

    assign status_clr = (wr && wb_adr_i == REG_INT_STATUS) ? sd_int_status_t'(wb_dat_i[3:0])
                                                           : sd_int_status_t'(4'b0);
    assign status_set = event_i.valid ? event_i.status : sd_int_status_t'(4'b0);

    always_comb begin
        rdata = 32'h0;
        case (wb_adr_i)
            REG_ARGUMENT:   rdata = argument_q;
            REG_COMMAND: begin
                rdata[CMD_INDEX_W-1:0] = cmd_index_q;
                rdata[CMD_RESP_BIT] = cmd_resp_q;
            end
            REG_RESPONSE:   rdata = response_q;
            REG_INT_STATUS: rdata[3:0] = int_status_q;
            REG_INT_ENABLE: rdata[3:0] = int_enable_q;
            REG_CLOCK_DIV:  rdata[DIV_W-1:0] = divisor_q;
            REG_PRESENT:    rdata[1:0] = {clk_stable_i, cmd_inhibit_i};
            default:        rdata = 32'h0;
        endcase
    end

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= 32'h0;
            held_q <= 1'b0;
            cmd_start_o <= 1'b0;
            cmd_index_q <= '0;
            cmd_resp_q <= RESP_NONE;
            int_status_q <= '0;
            int_enable_q <= '0;
            divisor_q <= DIVISOR_RESET;
        end else begin
            wb_ack_o <= access;
            held_q <= req & (held_q | wb_ack_o);
            cmd_start_o <= 1'b0;
            if (access) begin
                wb_dat_o <= rdata;
            end
            // W1C first, then new events are ORed in
            int_status_q <= (int_status_q & ~status_clr) | status_set;
            if (wr) begin
                case (wb_adr_i)
                    REG_COMMAND: begin
                        // dropped while a command is in flight
                        if (!cmd_inhibit_i) begin
                            cmd_index_q <= wb_dat_i[CMD_INDEX_W-1:0];
                            cmd_resp_q <= sd_resp_e'(wb_dat_i[CMD_RESP_BIT]);
                            cmd_start_o <= 1'b1;
                        end
                    end
                    REG_INT_ENABLE: int_enable_q <= wb_dat_i[3:0];
                    REG_CLOCK_DIV:  divisor_q <= wb_dat_i[DIV_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wr && wb_adr_i == REG_ARGUMENT) begin
            argument_q <= wb_dat_i;
        end
        if (event_i.valid) begin
            response_q <= event_i.response;
        end
    end

    assign cmd_req_o = '{index: cmd_index_q, argument: argument_q, resp: cmd_resp_q};
    assign divisor_o = divisor_q;
    assign int_o = |(int_status_q & int_enable_q);

    // no ack on consecutive cycles or twice within one held strobe
    a_ack_single: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        wb_ack_o |-> !$past(wb_ack_o) && !($past(wb_ack_o, 2) && $past(req, 2)));

endmodule

//--- rtl/sd_pkg.sv
package sd_pkg;

    localparam int CMD_FRAME_LEN = 48;
    localparam int CMD_INDEX_W = 6;
    localparam int ARG_W = 32;
    localparam int CRC7_W = 7;
    localparam int DIV_W = 8;
    localparam logic [DIV_W-1:0] DIVISOR_RESET = 8'd2;

    // response type position in COMMAND
    localparam int CMD_RESP_BIT = 8;

    typedef enum logic [7:0] {
        REG_ARGUMENT   = 8'h00,
        REG_COMMAND    = 8'h04,
        REG_RESPONSE   = 8'h08,
        REG_INT_STATUS = 8'h0C,
        REG_INT_ENABLE = 8'h10,
        REG_CLOCK_DIV  = 8'h14,
        REG_PRESENT    = 8'h18
    } sd_reg_addr_e;

    typedef enum logic {
        RESP_NONE  = 1'b0,
        RESP_SHORT = 1'b1
    } sd_resp_e;

    typedef struct packed {
        logic [CMD_INDEX_W-1:0] index;
        logic [ARG_W-1:0]       argument;
        sd_resp_e               resp;
    } sd_cmd_req_t;

    typedef struct packed {
        logic [CMD_INDEX_W-1:0] index;
        logic [ARG_W-1:0]       payload;
        logic                   crc_ok;
        logic                   timeout;
    } sd_cmd_frame_rsp_t;

    // msb first, so cmd_complete lands on bit 0
    typedef struct packed {
        logic timeout;
        logic index_error;
        logic crc_error;
        logic cmd_complete;
    } sd_int_status_t;

    typedef struct packed {
        logic             valid;
        sd_int_status_t   status;
        logic [ARG_W-1:0] response;
    } sd_cmd_event_t;

endpackage
